// File: common/dma_pkg.sv
// Shared widths, page geometry and payload types for the DMA legalizer
// Request, per-machine state, option and stream payload structs

`default_nettype none

package dma_pkg;

    // ------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------
    localparam int unsigned DataWidth     = 32;
    localparam int unsigned AddrWidth     = 24;
    localparam int unsigned StrbWidth     = DataWidth / 8;
    localparam int unsigned OffsetWidth   = $clog2(StrbWidth);
    // Page is 256 beats, capped at 4 KiB
    localparam int unsigned PageSize      = (256 * StrbWidth > 4096) ? 4096 : 256 * StrbWidth;
    localparam int unsigned PageAddrWidth = $clog2(PageSize);

    // ------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------
    typedef logic [AddrWidth-1:0]     addr_t;
    // One extra bit so a full page fits
    typedef logic [PageAddrWidth:0]   page_len_t;
    typedef logic [OffsetWidth-1:0]   offset_t;
    typedef logic [AddrWidth-1:0]     len_t;
    // AXI style, beats minus one
    typedef logic [7:0]               beats_t;

    // Incoming 1D copy request
    typedef struct packed {
        len_t       length;
        addr_t      src_addr;
        addr_t      dst_addr;
        logic [2:0] src_max_llen;
        logic       src_reduce_len;
        logic       last;
    } dma_req_t;

    // Mutable state of one machine
    typedef struct packed {
        len_t  length;
        addr_t addr;
        logic  valid;
    } mut_tf_t;

    // Options latched with the active transfer
    typedef struct packed {
        logic [2:0] src_max_llen;
        logic       src_reduce_len;
        offset_t    read_shift;
        offset_t    write_shift;
        logic       super_last;
    } tf_opt_t;

    // Read burst, address is word aligned
    typedef struct packed {
        addr_t   addr;
        beats_t  len;
        offset_t offset;
        offset_t tailer;
        offset_t shift;
        logic    is_single;
    } r_req_t;

    // Single-word write
    typedef struct packed {
        addr_t   addr;
        offset_t offset;
        offset_t tailer;
        offset_t shift;
        logic    last;
        logic    super_last;
    } w_req_t;

endpackage

`default_nettype wire

// File: common/burst_if.sv
// Valid/ready burst request stream with a busy level
// Payload type is a parameter, so read and write streams share it

`timescale 1ns/1ps
`default_nettype none

interface burst_if #(
    parameter type payload_t = logic
);

    // Source side
    logic     valid;
    payload_t payload;
    // High while the machine holds a live transfer
    logic     busy;

    // Sink side
    logic     ready;

    // Legalizer end
    modport source (
        output valid,
        output payload,
        output busy,
        input  ready
    );

    // Consumer end
    modport sink (
        input  valid,
        input  payload,
        input  busy,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/page_splitter.sv
// Distance in bytes to the next page, burst-length or word boundary
// Purely combinational

`timescale 1ns/1ps
`default_nettype none

module page_splitter #(
    parameter bit          NotBursting = 1'b0,
    parameter int unsigned AddrWidth   = dma_pkg::AddrWidth
) (
    input  wire  dma_pkg::addr_t     addr_i,
    input  wire  logic [2:0]         max_llen_i,
    input  wire  logic               reduce_len_i,
    output dma_pkg::page_len_t       bytes_to_pb_o
);

    import dma_pkg::*;

    page_len_t             word_bytes;
    page_len_t             page_bytes;
    page_len_t             block_bytes;
    logic [AddrWidth-1:0]  block_size;
    logic [AddrWidth-1:0]  block_off;

    always_comb begin
        // Bytes left in the current data word
        word_bytes  = page_len_t'(StrbWidth) - page_len_t'(addr_i[OffsetWidth-1:0]);

        // Bytes left in the current page
        page_bytes  = page_len_t'(PageSize) - page_len_t'(addr_i[PageAddrWidth-1:0]);

        // Aligned block of StrbWidth << max_llen bytes
        block_size  = AddrWidth'(StrbWidth) << max_llen_i;
        block_off   = AddrWidth'(addr_i) & (block_size - 1'b1);
        // Block never exceeds a page, so the cut is safe
        block_bytes = page_len_t'(block_size - block_off);

        if (NotBursting) begin
            // One word per request
            bytes_to_pb_o = word_bytes;
        end else if (reduce_len_i && (block_bytes < page_bytes)) begin
            // Reduced burst length wins when closer
            bytes_to_pb_o = block_bytes;
        end else begin
            bytes_to_pb_o = page_bytes;
        end
    end

endmodule

`default_nettype wire

// File: legalizer/legalizer_out.sv
// Read and write payload build from the legalizer state
// Drives valid, payload and busy of both streams

`timescale 1ns/1ps
`default_nettype none

module legalizer_out (
    input  wire  dma_pkg::mut_tf_t   r_tf_i,
    input  wire  dma_pkg::mut_tf_t   w_tf_i,
    input  wire  dma_pkg::tf_opt_t   opt_i,
    input  wire  dma_pkg::page_len_t r_num_bytes_i,
    input  wire  dma_pkg::page_len_t w_num_bytes_i,
    input  wire  logic               w_done_i,
    input  wire  logic               r_en_i,
    input  wire  logic               w_en_i,
    burst_if.source                  r_if,
    burst_if.source                  w_if
);

    import dma_pkg::*;

    offset_t   r_offset;
    offset_t   w_offset;
    // Bytes plus leading offset, spans the beats touched
    page_len_t r_span;
    page_len_t w_span;

    assign r_offset = r_tf_i.addr[OffsetWidth-1:0];
    assign w_offset = w_tf_i.addr[OffsetWidth-1:0];
    assign r_span   = r_num_bytes_i + page_len_t'(r_offset);
    assign w_span   = w_num_bytes_i + page_len_t'(w_offset);

    // ------------------------------------------------------------
    // Read stream
    // ------------------------------------------------------------
    always_comb begin
        r_if.payload.addr      = {r_tf_i.addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
        // Last byte index in words
        r_if.payload.len       = beats_t'((r_span - 1'b1) >> OffsetWidth);
        r_if.payload.offset    = r_offset;
        r_if.payload.tailer    = offset_t'(r_span);
        r_if.payload.shift     = opt_i.read_shift;
        r_if.payload.is_single = (r_num_bytes_i <= page_len_t'(StrbWidth));
    end

    assign r_if.valid = r_tf_i.valid & r_en_i;
    assign r_if.busy  = r_tf_i.valid;

    // ------------------------------------------------------------
    // Write stream
    // ------------------------------------------------------------
    always_comb begin
        w_if.payload.addr       = {w_tf_i.addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
        w_if.payload.offset     = w_offset;
        w_if.payload.tailer     = offset_t'(w_span);
        w_if.payload.shift      = opt_i.write_shift;
        // Final word of this 1D transfer
        w_if.payload.last       = w_done_i;
        w_if.payload.super_last = opt_i.super_last;
    end

    assign w_if.valid = w_tf_i.valid & w_en_i;
    assign w_if.busy  = w_tf_i.valid;

endmodule

`default_nettype wire

// File: legalizer/legalizer_core.sv
// Legalizer core: read, write and option state
// Boundary checks for both machines, refill, kill and flow control

`timescale 1ns/1ps
`default_nettype none

module legalizer_core #(
    parameter int unsigned DataWidth = dma_pkg::DataWidth,
    parameter int unsigned AddrWidth = dma_pkg::AddrWidth
) (
    input  wire  logic              clk_i,
    input  wire  logic              rst_n_i,
    input  wire  dma_pkg::dma_req_t req_i,
    input  wire  logic              valid_i,
    output logic                    ready_o,
    input  wire  logic              flush_i,
    input  wire  logic              kill_i,
    burst_if.source                 r_if,
    burst_if.source                 w_if
);

    import dma_pkg::*;

    // Byte offset width of the data word
    localparam int unsigned OffW = $clog2(DataWidth / 8);

    // State
    mut_tf_t   r_tf_d, r_tf_q;
    mut_tf_t   w_tf_d, w_tf_q;
    tf_opt_t   opt_d,  opt_q;

    // Boundary distances
    page_len_t r_bytes_pb;
    page_len_t w_bytes_pb;

    // Bytes in the burst on offer
    page_len_t r_num_bytes;
    page_len_t w_num_bytes;
    logic      r_done;
    logic      w_done;

    // Emit and register enables
    logic      r_en;
    logic      w_en;

    // ------------------------------------------------------------
    // Boundary checks
    // ------------------------------------------------------------
    // Read side bursts up to a page
    page_splitter #(
        .NotBursting (1'b0),
        .AddrWidth   (AddrWidth)
    ) u_read_splitter (
        .addr_i        (r_tf_q.addr),
        .max_llen_i    (opt_q.src_max_llen),
        .reduce_len_i  (opt_q.src_reduce_len),
        .bytes_to_pb_o (r_bytes_pb)
    );

    // OBI write side, one word at a time
    page_splitter #(
        .NotBursting (1'b1),
        .AddrWidth   (AddrWidth)
    ) u_write_splitter (
        .addr_i        (w_tf_q.addr),
        .max_llen_i    (3'd0),
        .reduce_len_i  (1'b0),
        .bytes_to_pb_o (w_bytes_pb)
    );

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        r_tf_d = r_tf_q;
        w_tf_d = w_tf_q;
        opt_d  = opt_q;
        r_done = 1'b0;
        w_done = 1'b0;

        // Read machine: cut at boundary or finish
        if (r_tf_q.length > len_t'(r_bytes_pb)) begin
            r_num_bytes   = r_bytes_pb;
            r_tf_d.length = r_tf_q.length - len_t'(r_bytes_pb);
            r_tf_d.addr   = r_tf_q.addr + addr_t'(r_bytes_pb);
        end else begin
            r_num_bytes   = r_tf_q.length[PageAddrWidth:0];
            r_tf_d.valid  = 1'b0;
            r_done        = 1'b1;
        end

        // Write machine, same rule with word boundary
        if (w_tf_q.length > len_t'(w_bytes_pb)) begin
            w_num_bytes   = w_bytes_pb;
            w_tf_d.length = w_tf_q.length - len_t'(w_bytes_pb);
            w_tf_d.addr   = w_tf_q.addr + addr_t'(w_bytes_pb);
        end else begin
            w_num_bytes   = w_tf_q.length[PageAddrWidth:0];
            w_tf_d.valid  = 1'b0;
            w_done        = 1'b1;
        end

        // Kill drops whatever is active
        if (kill_i) begin
            r_tf_d = '0;
            w_tf_d = '0;
            r_done = 1'b1;
            w_done = 1'b1;
        end

        // Refill both machines and the options
        if (ready_o && valid_i) begin
            r_tf_d = '{length: req_i.length, addr: req_i.src_addr, valid: 1'b1};
            w_tf_d = '{length: req_i.length, addr: req_i.dst_addr, valid: 1'b1};
            opt_d  = '{
                src_max_llen:   req_i.src_max_llen,
                src_reduce_len: req_i.src_reduce_len,
                // Split shifters: align on read, realign on write
                read_shift:     offset_t'(req_i.src_addr[OffW-1:0]),
                write_shift:    offset_t'(-req_i.dst_addr[OffW-1:0]),
                super_last:     req_i.last
            };
        end
    end

    // ------------------------------------------------------------
    // Flow control
    // ------------------------------------------------------------
    // Machines advance independently, OBI writes never couple
    assign r_en    = r_if.ready & ~flush_i;
    assign w_en    = w_if.ready & ~flush_i;

    // New request only once both machines are on their last burst
    assign ready_o = r_done & w_done & r_if.ready & w_if.ready & ~flush_i;

    // ------------------------------------------------------------
    // State registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            r_tf_q <= '0;
            w_tf_q <= '0;
            opt_q  <= '0;
        end else begin
            opt_q <= opt_d;
            if (r_en || kill_i) begin
                r_tf_q <= r_tf_d;
            end
            if (w_en || kill_i) begin
                w_tf_q <= w_tf_d;
            end
        end
    end

    // Payload build and stream drive
    legalizer_out u_out (
        .r_tf_i        (r_tf_q),
        .w_tf_i        (w_tf_q),
        .opt_i         (opt_q),
        .r_num_bytes_i (r_num_bytes),
        .w_num_bytes_i (w_num_bytes),
        .w_done_i      (w_done),
        .r_en_i        (r_en),
        .w_en_i        (w_en),
        .r_if          (r_if),
        .w_if          (w_if)
    );

endmodule

`default_nettype wire

// File: hdl/dma_legalizer_top.sv
// DMA legalizer top level with plain ports
// Packs the request, holds both stream interfaces, fans out the payloads

`timescale 1ns/1ps
`default_nettype none

module dma_legalizer_top #(
    parameter int unsigned DataWidth = dma_pkg::DataWidth,
    parameter int unsigned AddrWidth = dma_pkg::AddrWidth
) (
    input  wire  logic             clk_i,
    input  wire  logic             rst_n_i,
    // Request
    input  wire  logic             req_valid_i,
    output logic                   req_ready_o,
    input  wire  dma_pkg::len_t    req_length_i,
    input  wire  dma_pkg::addr_t   req_src_addr_i,
    input  wire  dma_pkg::addr_t   req_dst_addr_i,
    input  wire  logic [2:0]       req_src_max_llen_i,
    input  wire  logic             req_src_reduce_len_i,
    input  wire  logic             req_last_i,
    // Control
    input  wire  logic             flush_i,
    input  wire  logic             kill_i,
    // Read bursts
    output logic                   r_valid_o,
    input  wire  logic             r_ready_i,
    output dma_pkg::addr_t         r_addr_o,
    output dma_pkg::beats_t        r_len_o,
    output dma_pkg::offset_t       r_offset_o,
    output dma_pkg::offset_t       r_tailer_o,
    output dma_pkg::offset_t       r_shift_o,
    output logic                   r_single_o,
    output logic                   r_busy_o,
    // Write words
    output logic                   w_valid_o,
    input  wire  logic             w_ready_i,
    output dma_pkg::addr_t         w_addr_o,
    output dma_pkg::offset_t       w_offset_o,
    output dma_pkg::offset_t       w_tailer_o,
    output dma_pkg::offset_t       w_shift_o,
    output logic                   w_last_o,
    output logic                   w_super_last_o,
    output logic                   w_busy_o
);

    import dma_pkg::*;

    dma_req_t req;

    burst_if #(.payload_t(r_req_t)) u_r_if ();
    burst_if #(.payload_t(w_req_t)) u_w_if ();

    assign req = '{
        length:         req_length_i,
        src_addr:       req_src_addr_i,
        dst_addr:       req_dst_addr_i,
        src_max_llen:   req_src_max_llen_i,
        src_reduce_len: req_src_reduce_len_i,
        last:           req_last_i
    };

    legalizer_core #(
        .DataWidth (DataWidth),
        .AddrWidth (AddrWidth)
    ) u_core (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req),
        .valid_i (req_valid_i),
        .ready_o (req_ready_o),
        .flush_i (flush_i),
        .kill_i  (kill_i),
        .r_if    (u_r_if),
        .w_if    (u_w_if)
    );

    // Sink side of the read stream
    assign u_r_if.ready = r_ready_i;
    assign r_valid_o    = u_r_if.valid;
    assign r_addr_o     = u_r_if.payload.addr;
    assign r_len_o      = u_r_if.payload.len;
    assign r_offset_o   = u_r_if.payload.offset;
    assign r_tailer_o   = u_r_if.payload.tailer;
    assign r_shift_o    = u_r_if.payload.shift;
    assign r_single_o   = u_r_if.payload.is_single;
    assign r_busy_o     = u_r_if.busy;

    // Sink side of the write stream
    assign u_w_if.ready   = w_ready_i;
    assign w_valid_o      = u_w_if.valid;
    assign w_addr_o       = u_w_if.payload.addr;
    assign w_offset_o     = u_w_if.payload.offset;
    assign w_tailer_o     = u_w_if.payload.tailer;
    assign w_shift_o      = u_w_if.payload.shift;
    assign w_last_o       = u_w_if.payload.last;
    assign w_super_last_o = u_w_if.payload.super_last;
    assign w_busy_o       = u_w_if.busy;

endmodule

`default_nettype wire

// File: sim/tb_dma_legalizer.sv
// Testbench for the DMA legalizer top level
// Stimulus table, reference burst model, stream monitor and checks

`timescale 1ns/1ps
`default_nettype none

module tb_dma_legalizer;

    localparam int unsigned PageBytes = 1024;
    localparam int unsigned WordBytes = 4;
    localparam int          Timeout   = 20000;
    localparam int          NumTests  = 9;

    // Special handling per entry
    localparam logic [1:0] ModeNormal = 2'd0;
    localparam logic [1:0] ModeFlush  = 2'd1;
    localparam logic [1:0] ModeKill   = 2'd2;

    typedef struct packed {
        logic [23:0] length;
        logic [23:0] src;
        logic [23:0] dst;
        logic [2:0]  max_llen;
        logic        reduce;
        logic        last;
        logic [7:0]  ready_pct;
        logic [1:0]  mode;
    } entry_t;

    // length, src, dst, max_llen, reduce, last, ready percent, mode
    localparam entry_t Stim [NumTests] = '{
        '{24'd4,    24'h000100, 24'h000200, 3'd0, 1'b0, 1'b1, 8'd100, ModeNormal},
        '{24'd3,    24'h000101, 24'h000302, 3'd0, 1'b0, 1'b0, 8'd100, ModeNormal},
        '{24'd200,  24'h0003f0, 24'h001003, 3'd0, 1'b0, 1'b1, 8'd100, ModeNormal},
        '{24'd100,  24'h002006, 24'h004010, 3'd2, 1'b1, 1'b0, 8'd100, ModeNormal},
        '{24'd150,  24'h007fa1, 24'h000c05, 3'd3, 1'b1, 1'b1, 8'd50,  ModeNormal},
        '{24'd1100, 24'h0001f3, 24'h008002, 3'd0, 1'b0, 1'b0, 8'd70,  ModeNormal},
        '{24'd64,   24'h000040, 24'h000080, 3'd0, 1'b0, 1'b1, 8'd100, ModeFlush},
        '{24'd80,   24'h000010, 24'h000020, 3'd0, 1'b0, 1'b0, 8'd100, ModeKill},
        '{24'd37,   24'h0003fe, 24'h000011, 3'd1, 1'b1, 1'b1, 8'd100, ModeNormal}
    };

    function automatic string test_name(input int idx);
        case (idx)
            0: return "single_word";
            1: return "unaligned_word";
            2: return "page_cross";
            3: return "reduce_len";
            4: return "reduce_backpressure";
            5: return "page_backpressure";
            6: return "flush_hold";
            7: return "kill_mid";
            default: return "after_kill";
        endcase
    endfunction

    // ------------------------------------------------------------
    // DUT and its signals
    // ------------------------------------------------------------
    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        req_valid_i;
    logic        req_ready_o;
    logic [23:0] req_length_i;
    logic [23:0] req_src_addr_i;
    logic [23:0] req_dst_addr_i;
    logic [2:0]  req_src_max_llen_i;
    logic        req_src_reduce_len_i;
    logic        req_last_i;
    logic        flush_i;
    logic        kill_i;
    logic        r_valid_o;
    logic        r_ready_i = 1'b1;
    logic [23:0] r_addr_o;
    logic [7:0]  r_len_o;
    logic [1:0]  r_offset_o;
    logic [1:0]  r_tailer_o;
    logic [1:0]  r_shift_o;
    logic        r_single_o;
    logic        r_busy_o;
    logic        w_valid_o;
    logic        w_ready_i = 1'b1;
    logic [23:0] w_addr_o;
    logic [1:0]  w_offset_o;
    logic [1:0]  w_tailer_o;
    logic [1:0]  w_shift_o;
    logic        w_last_o;
    logic        w_super_last_o;
    logic        w_busy_o;

    // Expected bursts, packed like the DUT ports
    logic [63:0] r_exp [$];
    logic [63:0] w_exp [$];
    string       cur_name = "reset";
    int unsigned ready_pct = 100;

    dma_legalizer_top dut (
        .clk_i                (clk),
        .rst_n_i              (rst_n_i),
        .req_valid_i          (req_valid_i),
        .req_ready_o          (req_ready_o),
        .req_length_i         (req_length_i),
        .req_src_addr_i       (req_src_addr_i),
        .req_dst_addr_i       (req_dst_addr_i),
        .req_src_max_llen_i   (req_src_max_llen_i),
        .req_src_reduce_len_i (req_src_reduce_len_i),
        .req_last_i           (req_last_i),
        .flush_i              (flush_i),
        .kill_i               (kill_i),
        .r_valid_o            (r_valid_o),
        .r_ready_i            (r_ready_i),
        .r_addr_o             (r_addr_o),
        .r_len_o              (r_len_o),
        .r_offset_o           (r_offset_o),
        .r_tailer_o           (r_tailer_o),
        .r_shift_o            (r_shift_o),
        .r_single_o           (r_single_o),
        .r_busy_o             (r_busy_o),
        .w_valid_o            (w_valid_o),
        .w_ready_i            (w_ready_i),
        .w_addr_o             (w_addr_o),
        .w_offset_o           (w_offset_o),
        .w_tailer_o           (w_tailer_o),
        .w_shift_o            (w_shift_o),
        .w_last_o             (w_last_o),
        .w_super_last_o       (w_super_last_o),
        .w_busy_o             (w_busy_o)
    );

    always #20 clk = ~clk;

    // Random back-pressure, probability in percent
    always @(posedge clk) begin
        r_ready_i <= ($urandom_range(99) < ready_pct);
        w_ready_i <= ($urandom_range(99) < ready_pct);
    end

    // ------------------------------------------------------------
    // Checks and reference model
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic build_expected(input entry_t e);
        int unsigned addr;
        int unsigned rem;
        int unsigned bytes;
        int unsigned block;
        int unsigned num;
        int unsigned off;
        int unsigned span;
        // Read side, cut at page or reduced block
        addr = e.src;
        rem  = e.length;
        while (rem != 0) begin
            bytes = PageBytes - (addr % PageBytes);
            block = WordBytes << e.max_llen;
            if (e.reduce && ((block - (addr % block)) < bytes)) begin
                bytes = block - (addr % block);
            end
            num  = (rem > bytes) ? bytes : rem;
            off  = addr % WordBytes;
            span = num + off;
            r_exp.push_back(64'({24'(addr - off), 8'((span - 1) >> 2), 2'(off), 2'(span),
                                 2'(e.src), (num <= WordBytes)}));
            rem  = rem - num;
            addr = addr + num;
        end
        // Write side, one word per request
        addr = e.dst;
        rem  = e.length;
        while (rem != 0) begin
            bytes = WordBytes - (addr % WordBytes);
            num   = (rem > bytes) ? bytes : rem;
            off   = addr % WordBytes;
            span  = num + off;
            w_exp.push_back(64'({24'(addr - off), 2'(off), 2'(span),
                                 2'(WordBytes - (e.dst % WordBytes)), (rem == num), e.last}));
            rem   = rem - num;
            addr  = addr + num;
        end
    endtask

    // Stream monitor, mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n_i) begin
            // New request only while both streams are on their last burst
            if ((r_busy_o || w_busy_o) && req_ready_o && !kill_i) begin
                check_value({cur_name, " early ready"}, 64'd1,
                            64'((r_exp.size() <= 1) && (w_exp.size() <= 1)));
            end
            // Beats offered under kill belong to the dropped transfer
            if (r_valid_o && !kill_i) begin
                if (r_exp.size() == 0) begin
                    fail_run({"unexpected read burst in ", cur_name});
                end else begin
                    check_value({cur_name, " read"}, r_exp.pop_front(),
                                64'({r_addr_o, r_len_o, r_offset_o, r_tailer_o,
                                     r_shift_o, r_single_o}));
                end
            end
            if (w_valid_o && !kill_i) begin
                if (w_exp.size() == 0) begin
                    fail_run({"unexpected write request in ", cur_name});
                end else begin
                    check_value({cur_name, " write"}, w_exp.pop_front(),
                                64'({w_addr_o, w_offset_o, w_tailer_o, w_shift_o,
                                     w_last_o, w_super_last_o}));
                end
            end
        end
    end

    task automatic wait_accept(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!req_ready_o && (cycles < Timeout)) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!req_ready_o) begin
            fail_run({"request was never accepted in ", name});
        end
    endtask

    // Both machines idle means every burst went out
    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((r_busy_o || w_busy_o) && (cycles < Timeout)) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (r_busy_o || w_busy_o) begin
            fail_run({"transfer did not finish in ", name});
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        entry_t      e;
        logic [23:0] held_r;
        logic [23:0] held_w;
        void'($urandom(32'h200b));
        rst_n_i              = 1'b0;
        req_valid_i          = 1'b0;
        req_length_i         = '0;
        req_src_addr_i       = '0;
        req_dst_addr_i       = '0;
        req_src_max_llen_i   = '0;
        req_src_reduce_len_i = 1'b0;
        req_last_i           = 1'b0;
        flush_i              = 1'b0;
        kill_i               = 1'b0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int i = 0; i < NumTests; i++) begin
            e = Stim[i];
            @(negedge clk);
            cur_name  = test_name(i);
            ready_pct = e.ready_pct;
            build_expected(e);
            @(posedge clk);
            req_valid_i          <= 1'b1;
            req_length_i         <= e.length;
            req_src_addr_i       <= e.src;
            req_dst_addr_i       <= e.dst;
            req_src_max_llen_i   <= e.max_llen;
            req_src_reduce_len_i <= e.reduce;
            req_last_i           <= e.last;
            wait_accept(cur_name);
            @(posedge clk);
            req_valid_i <= 1'b0;

            if (e.mode == ModeFlush) begin
                repeat (3) @(posedge clk);
                flush_i <= 1'b1;
                @(negedge clk);
                held_r = r_addr_o;
                held_w = w_addr_o;
                // Nothing offered, nothing moves
                repeat (4) begin
                    check_value({cur_name, " flush valid"}, 64'd0,
                                64'({r_valid_o, w_valid_o, req_ready_o}));
                    check_value({cur_name, " flush hold"}, 64'({held_r, held_w}),
                                64'({r_addr_o, w_addr_o}));
                    @(negedge clk);
                end
                @(posedge clk);
                flush_i <= 1'b0;
                wait_done(cur_name);
            end else if (e.mode == ModeKill) begin
                repeat (3) @(posedge clk);
                kill_i <= 1'b1;
                @(posedge clk);
                kill_i <= 1'b0;
                @(negedge clk);
                check_value({cur_name, " busy after kill"}, 64'd0, 64'({r_busy_o, w_busy_o}));
                // Dropped bursts are no longer expected
                @(posedge clk);
                r_exp.delete();
                w_exp.delete();
            end else begin
                wait_done(cur_name);
            end

            if (e.mode != ModeKill) begin
                @(posedge clk);
                check_value({cur_name, " reads left"}, 64'd0, 64'(r_exp.size()));
                check_value({cur_name, " writes left"}, 64'd0, 64'(w_exp.size()));
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/dma_pkg.sv
common/burst_if.sv
hdl/page_splitter.sv
legalizer/legalizer_out.sv
legalizer/legalizer_core.sv
hdl/dma_legalizer_top.sv
sim/tb_dma_legalizer.sv

// File: run.sh
#!/bin/sh
# Build the DMA legalizer testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_dma_legalizer \
    -Mdir obj_dir -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
# Any reported failure, or a log without a verdict, fails the run
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
